// ==== bench/tb_reg_file.sv ====
/* directed testbench for mips_reg_file with a reference model of both banks,
   HI/LO and the registered read outputs */
module tb_reg_file;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int LINK_IDX   = 31;
	localparam int MAX_CYCLES = 400; // tests need about 35 cycles
	localparam int AW         = reg_file_pkg::REG_ADDR_W;
	localparam int DW         = reg_file_pkg::XLEN;

	logic                   Clk;
	logic                   rst_n_i;
	logic                   reg_write_i;
	logic                   load_byte_i;
	logic                   jal_i;
	logic                   float_write_i;
	logic                   muldiv_i;
	logic                   wide_write_i;
	logic [AW-1:0]          wr_addr_i;
	logic [DW-1:0]          wr_data_i;
	logic [2*DW-1:0]        wr_data64_i;
	logic                   store_byte_i;
	logic                   float_read_i;
	logic                   store_fp_i;
	logic [AW-1:0]          rs_i;
	logic [AW-1:0]          rt_i;
	reg_file_pkg::rd_data_t rd_data_o;

	logic [DW-1:0]          int_mdl [32];
	logic [DW-1:0]          fp_mdl [32]; // msw at even index
	logic [DW-1:0]          hi_mdl;
	logic [DW-1:0]          lo_mdl;
	reg_file_pkg::rd_data_t exp_q;       // predicted output register
	reg_file_pkg::rd_op_e   rd_kind;     // read op currently driven
	integer                 seed;
	int                     cycle_cnt = 0;

	mips_reg_file #(.LINK_REG(LINK_IDX)) u_dut (
		.Clk(Clk), .rst_n_i(rst_n_i), .reg_write_i(reg_write_i),
		.load_byte_i(load_byte_i), .jal_i(jal_i), .float_write_i(float_write_i),
		.muldiv_i(muldiv_i), .wide_write_i(wide_write_i), .wr_addr_i(wr_addr_i),
		.wr_data_i(wr_data_i), .wr_data64_i(wr_data64_i), .store_byte_i(store_byte_i),
		.float_read_i(float_read_i), .store_fp_i(store_fp_i), .rs_i(rs_i), .rt_i(rt_i),
		.rd_data_o(rd_data_o)
	);

	always #5 Clk = ~Clk;

	always @(posedge Clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout, tests still running after %0d cycles", cycle_cnt);
		end
	end

	task automatic check(input string name, input logic [DW-1:0] actual,
	                     input logic [DW-1:0] expected);
		if (actual !== expected) begin
			$display("ERROR: time %0t signal %s expected %h actual %h",
			         $time, name, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic next_cycle();
		@(posedge Clk);
		#1; // inputs change just after the edge
	endtask

	task automatic check_outputs();
		check("rd_data_o.rs_data", rd_data_o.rs_data, exp_q.rs_data);
		check("rd_data_o.rs_msw", rd_data_o.rs_msw, exp_q.rs_msw);
		check("rd_data_o.rt_data", rd_data_o.rt_data, exp_q.rt_data);
		check("rd_data_o.rt_msw", rd_data_o.rt_msw, exp_q.rt_msw);
		check("rd_data_o.hi", rd_data_o.hi, exp_q.hi);
		check("rd_data_o.lo", rd_data_o.lo, exp_q.lo);
	endtask

	// next output register value, from model contents before the edge
	task automatic predict_read();
		logic [DW-1:0] rt_word;
		rt_word  = int_mdl[rt_i];
		exp_q.hi = hi_mdl;
		exp_q.lo = lo_mdl;
		case (rd_kind)
			reg_file_pkg::RD_INT: begin
				exp_q.rs_data = int_mdl[rs_i];
				exp_q.rt_data = rt_word;
			end
			reg_file_pkg::RD_STORE_BYTE: begin
				exp_q.rs_data = int_mdl[rs_i];
				exp_q.rt_data = {24'h0, rt_word[7:0]};
			end
			reg_file_pkg::RD_FP: begin
				if (!rs_i[0]) begin
					exp_q.rs_data = fp_mdl[{rs_i[AW-1:1], 1'b1}];
					exp_q.rs_msw  = fp_mdl[rs_i];
				end
				if (!rt_i[0]) begin
					exp_q.rt_data = fp_mdl[{rt_i[AW-1:1], 1'b1}];
					exp_q.rt_msw  = fp_mdl[rt_i];
				end
			end
			reg_file_pkg::RD_STORE_FP: begin
				exp_q.rs_data = int_mdl[rs_i];
				if (!rt_i[0]) begin
					exp_q.rt_data = fp_mdl[{rt_i[AW-1:1], 1'b1}];
					exp_q.rt_msw  = fp_mdl[rt_i];
				end
			end
		endcase
	endtask

	// one write cycle; the read port keeps sampling whatever is driven
	task automatic do_write(input reg_file_pkg::wr_op_e op, input logic [AW-1:0] addr,
	                        input logic [DW-1:0] data, input logic [2*DW-1:0] data64);
		reg_write_i   = 1'b1;
		load_byte_i   = (op == reg_file_pkg::WR_INT_BYTE);
		jal_i         = (op == reg_file_pkg::WR_LINK);
		float_write_i = (op == reg_file_pkg::WR_FP64) || (op == reg_file_pkg::WR_FP32);
		wide_write_i  = (op == reg_file_pkg::WR_FP64) || (op == reg_file_pkg::WR_HILO);
		muldiv_i      = (op == reg_file_pkg::WR_HILO);
		wr_addr_i     = addr;
		wr_data_i     = data;
		wr_data64_i   = data64;
		predict_read();
		case (op)
			reg_file_pkg::WR_INT:
				if (addr != '0) int_mdl[addr] = data;
			reg_file_pkg::WR_INT_BYTE:
				if (addr != '0) int_mdl[addr] = {24'h0, data[7:0]};
			reg_file_pkg::WR_LINK:
				int_mdl[LINK_IDX] = data; // wr_addr_i plays no part
			reg_file_pkg::WR_FP64: begin
				fp_mdl[addr]                     = data64[63:32];
				fp_mdl[{addr[AW-1:1], 1'b1}]     = data64[31:0];
			end
			reg_file_pkg::WR_FP32: begin
				fp_mdl[addr]                     = '0;
				fp_mdl[{addr[AW-1:1], 1'b1}]     = data;
			end
			reg_file_pkg::WR_HILO: begin
				hi_mdl = data64[63:32];
				lo_mdl = data64[31:0];
			end
			default: ;
		endcase
		next_cycle();
		reg_write_i   = 1'b0;
		load_byte_i   = 1'b0;
		jal_i         = 1'b0;
		float_write_i = 1'b0;
		wide_write_i  = 1'b0;
		muldiv_i      = 1'b0;
		check_outputs();
	endtask

	task automatic read_and_check(input reg_file_pkg::rd_op_e op,
	                              input logic [AW-1:0] rs, input logic [AW-1:0] rt);
		store_byte_i = (op == reg_file_pkg::RD_STORE_BYTE);
		float_read_i = (op == reg_file_pkg::RD_FP);
		store_fp_i   = (op == reg_file_pkg::RD_STORE_FP);
		rs_i         = rs;
		rt_i         = rt;
		rd_kind      = op;
		predict_read();
		next_cycle();
		check_outputs();
	endtask

	task automatic test_int_rw();
		int idx_list [4] = '{1, 7, 15, LINK_IDX}; // link index included
		for (int i = 0; i < 4; i++)
			do_write(reg_file_pkg::WR_INT, AW'(idx_list[i]), $random(seed), '0);
		read_and_check(reg_file_pkg::RD_INT, AW'(idx_list[0]), AW'(idx_list[1]));
		read_and_check(reg_file_pkg::RD_INT, AW'(idx_list[2]), AW'(idx_list[3]));
		do_write(reg_file_pkg::WR_INT, 5'd0, 32'hdead_beef, '0);
		read_and_check(reg_file_pkg::RD_INT, 5'd0, 5'd0); // r0 stays zero
	endtask

	task automatic test_byte();
		do_write(reg_file_pkg::WR_INT_BYTE, 5'd9, $random(seed), '0);
		read_and_check(reg_file_pkg::RD_INT, 5'd9, 5'd9);
		do_write(reg_file_pkg::WR_INT, 5'd10, 32'h1234_56a5, '0);
		read_and_check(reg_file_pkg::RD_STORE_BYTE, 5'd10, 5'd10); // rs full, rt byte
	endtask

	task automatic test_jal();
		do_write(reg_file_pkg::WR_INT, 5'd5, 32'h0000_0055, '0);
		do_write(reg_file_pkg::WR_LINK, 5'd5, $random(seed), '0);
		read_and_check(reg_file_pkg::RD_INT, AW'(LINK_IDX), 5'd5);
	endtask

	task automatic test_fp_pairs();
		do_write(reg_file_pkg::WR_FP64, 5'd4, '0, {$random(seed), $random(seed)});
		do_write(reg_file_pkg::WR_FP64, 5'd10, '0, {$random(seed), $random(seed)});
		read_and_check(reg_file_pkg::RD_FP, 5'd4, 5'd10);
		do_write(reg_file_pkg::WR_FP32, 5'd6, $random(seed), '0);
		read_and_check(reg_file_pkg::RD_FP, 5'd6, 5'd4);  // single has msw zero
		read_and_check(reg_file_pkg::RD_FP, 5'd5, 5'd11); // both ports hold
		read_and_check(reg_file_pkg::RD_FP, 5'd10, 5'd7);
	endtask

	task automatic test_store_fp();
		do_write(reg_file_pkg::WR_INT, 5'd12, $random(seed), '0);
		do_write(reg_file_pkg::WR_FP64, 5'd20, '0, {$random(seed), $random(seed)});
		read_and_check(reg_file_pkg::RD_STORE_FP, 5'd12, 5'd20);
		read_and_check(reg_file_pkg::RD_INT, 5'd12, 5'd20); // msw fields hold
	endtask

	task automatic test_hilo();
		logic [2*DW-1:0] d64;
		d64 = {$random(seed), $random(seed)};
		do_write(reg_file_pkg::WR_HILO, 5'd0, '0, d64);
		for (int i = 0; i < 3; i++) begin
			do_write(reg_file_pkg::WR_INT, AW'(13 + i), $random(seed), '0);
			check("rd_data_o.hi", rd_data_o.hi, d64[63:32]);
			check("rd_data_o.lo", rd_data_o.lo, d64[31:0]);
		end
	endtask

	initial begin
		seed          = 32'hd3fa;
		Clk           = 1'b0;
		rst_n_i       = 1'b0;
		reg_write_i   = 1'b0;
		load_byte_i   = 1'b0;
		jal_i         = 1'b0;
		float_write_i = 1'b0;
		muldiv_i      = 1'b0;
		wide_write_i  = 1'b0;
		wr_addr_i     = '0;
		wr_data_i     = '0;
		wr_data64_i   = '0;
		store_byte_i  = 1'b0;
		float_read_i  = 1'b0;
		store_fp_i    = 1'b0;
		rs_i          = '0;
		rt_i          = '0;
		rd_kind       = reg_file_pkg::RD_INT;
		exp_q         = '0;
		hi_mdl        = '0;
		lo_mdl        = '0;
		for (int i = 0; i < 32; i++) begin
			int_mdl[i] = '0;
			fp_mdl[i]  = '0;
		end
		repeat (4) @(posedge Clk);
		#1;
		rst_n_i = 1'b1;
		check_outputs(); // everything cleared by reset
		test_int_rw();
		test_byte();
		test_jal();
		test_fp_pairs();
		test_store_fp();
		test_hilo();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# builds the register file testbench with Verilator and runs it
# the exit status of the simulation is the pass/fail result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f src.f \
	--top-module tb_reg_file \
	-o sim_tb_reg_file

./obj_dir/sim_tb_reg_file

// ==== source/fp_reg_bank.sv ====
/* floating-point bank kept as 16 even/odd pairs holding doubles
   msw sits at the even index, reads are combinational per pair */
module fp_reg_bank (
	input  logic                                Clk,
	input  logic                                rst_n_i,
	input  reg_file_pkg::wr_cmd_t               wr_cmd_i,
	input  logic [reg_file_pkg::REG_ADDR_W-1:0] rs_i,
	input  logic [reg_file_pkg::REG_ADDR_W-1:0] rt_i,
	output reg_file_pkg::fp_pair_t              rs_pair_o,
	output reg_file_pkg::fp_pair_t              rt_pair_o
);

	localparam int PAIR_W = reg_file_pkg::REG_ADDR_W - 1;
	localparam int NPAIRS = 2**PAIR_W;

	reg_file_pkg::fp_pair_t pair_q [NPAIRS];
	reg_file_pkg::fp_pair_t wr_pair;
	logic                   fp_wr;
	logic [PAIR_W-1:0]      wr_pair_idx;

	always_comb begin
		fp_wr       = (wr_cmd_i.op == reg_file_pkg::WR_FP64) ||
		              (wr_cmd_i.op == reg_file_pkg::WR_FP32);
		wr_pair_idx = wr_cmd_i.addr[reg_file_pkg::REG_ADDR_W-1:1];
		if (wr_cmd_i.op == reg_file_pkg::WR_FP64) begin
			wr_pair = wr_cmd_i.data64;
		end else begin
			wr_pair.msw = '0; // single precision clears the upper word
			wr_pair.lsw = wr_cmd_i.data;
		end
	end

	always_ff @(posedge Clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NPAIRS; i++)
				pair_q[i] <= '0;
		end else if (fp_wr && !wr_cmd_i.addr[0]) begin // odd index ignored
			pair_q[wr_pair_idx] <= wr_pair;
		end
	end

	// odd addresses are filtered in the output mux
	assign rs_pair_o = pair_q[rs_i[reg_file_pkg::REG_ADDR_W-1:1]];
	assign rt_pair_o = pair_q[rt_i[reg_file_pkg::REG_ADDR_W-1:1]];

	// decoder should never hand us an odd pair address
	fp_even_wr_a: assert property (
		@(posedge Clk) disable iff (!rst_n_i)
		fp_wr |-> !wr_cmd_i.addr[0]
	) else $error("float write to odd register %0d dropped", wr_cmd_i.addr);

endmodule

// ==== source/int_reg_bank.sv ====
/* integer registers 1..31 plus HI/LO
   rising edge writes and two combinational read ports */
module int_reg_bank #(
	parameter int unsigned LINK_REG = 31
) (
	input  logic                                Clk,
	input  logic                                rst_n_i,
	input  reg_file_pkg::wr_cmd_t               wr_cmd_i,
	input  logic [reg_file_pkg::REG_ADDR_W-1:0] rs_i,
	input  logic [reg_file_pkg::REG_ADDR_W-1:0] rt_i,
	output logic [reg_file_pkg::XLEN-1:0]       rs_val_o,
	output logic [reg_file_pkg::XLEN-1:0]       rt_val_o,
	output reg_file_pkg::fp_pair_t              hilo_o
);

	localparam int NREGS = 2**reg_file_pkg::REG_ADDR_W;

	logic [reg_file_pkg::XLEN-1:0]       gpr_q [1:NREGS-1]; // no storage for r0
	reg_file_pkg::fp_pair_t              hilo_q;            // msw is HI
	logic                                wr_en;
	logic [reg_file_pkg::REG_ADDR_W-1:0] wr_idx;
	logic [reg_file_pkg::XLEN-1:0]       wr_word;

	always_comb begin
		wr_en   = (wr_cmd_i.op == reg_file_pkg::WR_INT) ||
		          (wr_cmd_i.op == reg_file_pkg::WR_INT_BYTE) ||
		          (wr_cmd_i.op == reg_file_pkg::WR_LINK);
		wr_idx  = wr_cmd_i.addr;
		wr_word = wr_cmd_i.data;
		if (wr_cmd_i.op == reg_file_pkg::WR_LINK)
			wr_idx = reg_file_pkg::REG_ADDR_W'(LINK_REG); // ignores wr addr
		if (wr_cmd_i.op == reg_file_pkg::WR_INT_BYTE)
			wr_word = {{(reg_file_pkg::XLEN-8){1'b0}}, wr_cmd_i.data[7:0]};
	end

	always_ff @(posedge Clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 1; i < NREGS; i++)
				gpr_q[i] <= '0;
			hilo_q <= '0;
		end else begin
			if (wr_en && (wr_idx != '0)) // writes to r0 are dropped
				gpr_q[wr_idx] <= wr_word;
			if (wr_cmd_i.op == reg_file_pkg::WR_HILO)
				hilo_q <= wr_cmd_i.data64; // upper half lands in HI
		end
	end

	// r0 is hardwired
	assign rs_val_o = (rs_i == '0) ? '0 : gpr_q[rs_i];
	assign rt_val_o = (rt_i == '0) ? '0 : gpr_q[rt_i];
	assign hilo_o   = hilo_q;

	// HI/LO may only move on the edge after a mul/div write
	hilo_hold_a: assert property (
		@(posedge Clk) disable iff (!rst_n_i)
		(wr_cmd_i.op != reg_file_pkg::WR_HILO) |=> $stable(hilo_q)
	) else $error("HI/LO changed without a WR_HILO command");

endmodule

// ==== source/mips_reg_file.sv ====
/* top level of the MIPS register file
   decoder, integer bank, float bank and registered read mux */
module mips_reg_file #(
	parameter int unsigned LINK_REG = 31
) (
	input  logic                                Clk,
	input  logic                                rst_n_i,
	input  logic                                reg_write_i,
	input  logic                                load_byte_i,
	input  logic                                jal_i,
	input  logic                                float_write_i,
	input  logic                                muldiv_i,
	input  logic                                wide_write_i,
	input  logic [reg_file_pkg::REG_ADDR_W-1:0] wr_addr_i,
	input  logic [reg_file_pkg::XLEN-1:0]       wr_data_i,
	input  logic [2*reg_file_pkg::XLEN-1:0]     wr_data64_i,
	input  logic                                store_byte_i,
	input  logic                                float_read_i,
	input  logic                                store_fp_i,
	input  logic [reg_file_pkg::REG_ADDR_W-1:0] rs_i,
	input  logic [reg_file_pkg::REG_ADDR_W-1:0] rt_i,
	output reg_file_pkg::rd_data_t              rd_data_o
);

	reg_file_pkg::wr_cmd_t         wr_cmd;
	reg_file_pkg::rd_req_t         rd_req;
	logic [reg_file_pkg::XLEN-1:0] int_rs_val;
	logic [reg_file_pkg::XLEN-1:0] int_rt_val;
	reg_file_pkg::fp_pair_t        hilo;
	reg_file_pkg::fp_pair_t        fp_rs_pair;
	reg_file_pkg::fp_pair_t        fp_rt_pair;

	reg_write_decode u_decode (
		.reg_write_i   (reg_write_i),
		.load_byte_i   (load_byte_i),
		.jal_i         (jal_i),
		.float_write_i (float_write_i),
		.muldiv_i      (muldiv_i),
		.wide_write_i  (wide_write_i),
		.wr_addr_i     (wr_addr_i),
		.wr_data_i     (wr_data_i),
		.wr_data64_i   (wr_data64_i),
		.store_byte_i  (store_byte_i),
		.float_read_i  (float_read_i),
		.store_fp_i    (store_fp_i),
		.rs_i          (rs_i),
		.rt_i          (rt_i),
		.wr_cmd_o      (wr_cmd),
		.rd_req_o      (rd_req)
	);

	int_reg_bank #(.LINK_REG(LINK_REG)) u_int_bank (
		.Clk(Clk), .rst_n_i(rst_n_i), .wr_cmd_i(wr_cmd),
		.rs_i(rd_req.rs), .rt_i(rd_req.rt),
		.rs_val_o(int_rs_val), .rt_val_o(int_rt_val), .hilo_o(hilo)
	);

	fp_reg_bank u_fp_bank (
		.Clk(Clk), .rst_n_i(rst_n_i), .wr_cmd_i(wr_cmd),
		.rs_i(rd_req.rs), .rt_i(rd_req.rt),
		.rs_pair_o(fp_rs_pair), .rt_pair_o(fp_rt_pair)
	);

	read_port_mux u_rd_mux (
		.Clk(Clk), .rst_n_i(rst_n_i), .rd_req_i(rd_req),
		.int_rs_i(int_rs_val), .int_rt_i(int_rt_val),
		.fp_rs_i(fp_rs_pair), .fp_rt_i(fp_rt_pair), .hilo_i(hilo),
		.rd_data_o(rd_data_o)
	);

endmodule

// ==== source/read_port_mux.sv ====
/* selects read data from both banks by read opcode and registers it
   fields not named by the opcode keep their last value */
module read_port_mux (
	input  logic                          Clk,
	input  logic                          rst_n_i,
	input  reg_file_pkg::rd_req_t         rd_req_i,
	input  logic [reg_file_pkg::XLEN-1:0] int_rs_i,
	input  logic [reg_file_pkg::XLEN-1:0] int_rt_i,
	input  reg_file_pkg::fp_pair_t        fp_rs_i,
	input  reg_file_pkg::fp_pair_t        fp_rt_i,
	input  reg_file_pkg::fp_pair_t        hilo_i,
	output reg_file_pkg::rd_data_t        rd_data_o
);

	reg_file_pkg::rd_data_t        rd_q;
	logic [reg_file_pkg::XLEN-1:0] rt_byte;
	logic                          rs_even;
	logic                          rt_even;
	logic                          fp_class;

	assign rt_byte  = {{(reg_file_pkg::XLEN-8){1'b0}}, int_rt_i[7:0]};
	assign rs_even  = !rd_req_i.rs[0];
	assign rt_even  = !rd_req_i.rt[0];
	assign fp_class = (rd_req_i.op == reg_file_pkg::RD_FP) ||
	                  (rd_req_i.op == reg_file_pkg::RD_STORE_FP);

	always_ff @(posedge Clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_q <= '0;
		end else begin
			rd_q.hi <= hilo_i.msw; // HI/LO tracked every cycle
			rd_q.lo <= hilo_i.lsw;
			case (rd_req_i.op)
				reg_file_pkg::RD_INT: begin
					rd_q.rs_data <= int_rs_i;
					rd_q.rt_data <= int_rt_i;
				end
				reg_file_pkg::RD_STORE_BYTE: begin
					rd_q.rs_data <= int_rs_i; // base address stays a full word
					rd_q.rt_data <= rt_byte;
				end
				reg_file_pkg::RD_FP: begin
					if (rs_even) begin
						rd_q.rs_data <= fp_rs_i.lsw;
						rd_q.rs_msw  <= fp_rs_i.msw;
					end
					if (rt_even) begin
						rd_q.rt_data <= fp_rt_i.lsw;
						rd_q.rt_msw  <= fp_rt_i.msw;
					end
				end
				reg_file_pkg::RD_STORE_FP: begin
					rd_q.rs_data <= int_rs_i; // integer base, float value
					if (rt_even) begin
						rd_q.rt_data <= fp_rt_i.lsw;
						rd_q.rt_msw  <= fp_rt_i.msw;
					end
				end
			endcase
		end
	end

	assign rd_data_o = rd_q;

	// upper words belong to float reads only
	msw_hold_a: assert property (
		@(posedge Clk) disable iff (!rst_n_i)
		!fp_class |=> ($stable(rd_q.rs_msw) && $stable(rd_q.rt_msw))
	) else $error("msw output changed on an integer-class read");

endmodule

// ==== source/reg_file_pkg.sv ====
/* widths, opcodes and packed bundles shared by the MIPS register file blocks
   referenced everywhere through the reg_file_pkg:: scope */
package reg_file_pkg;

	localparam int XLEN       = 32; // register word width
	localparam int REG_ADDR_W = 5;  // register index width

	// write operations, one per cycle at most
	typedef enum logic [2:0] {
		WR_NONE,
		WR_INT,      // full word to integer bank
		WR_INT_BYTE, // zero-extended low byte
		WR_LINK,     // return address after jal
		WR_FP64,     // double into a float pair
		WR_FP32,     // single into a float pair
		WR_HILO      // mul/div result
	} wr_op_e;

	typedef enum logic [1:0] {
		RD_INT,
		RD_STORE_BYTE,
		RD_FP,
		RD_STORE_FP
	} rd_op_e;

	typedef struct packed {
		logic [XLEN-1:0] msw; // even index
		logic [XLEN-1:0] lsw; // odd index
	} fp_pair_t;

	typedef struct packed {
		wr_op_e                op;
		logic [REG_ADDR_W-1:0] addr;
		logic [XLEN-1:0]       data;
		logic [2*XLEN-1:0]     data64;
	} wr_cmd_t;

	typedef struct packed {
		rd_op_e                op;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
	} rd_req_t;

	typedef struct packed {
		logic [XLEN-1:0] rs_data;
		logic [XLEN-1:0] rs_msw;
		logic [XLEN-1:0] rt_data;
		logic [XLEN-1:0] rt_msw;
		logic [XLEN-1:0] hi;
		logic [XLEN-1:0] lo;
	} rd_data_t;

endpackage

// ==== source/reg_write_decode.sv ====
/* turns the raw per-cycle control strobes into one write command
   and one read request for the banks and the output mux */
module reg_write_decode (
	input  logic                                reg_write_i,
	input  logic                                load_byte_i,
	input  logic                                jal_i,
	input  logic                                float_write_i,
	input  logic                                muldiv_i,
	input  logic                                wide_write_i,
	input  logic [reg_file_pkg::REG_ADDR_W-1:0] wr_addr_i,
	input  logic [reg_file_pkg::XLEN-1:0]       wr_data_i,
	input  logic [2*reg_file_pkg::XLEN-1:0]     wr_data64_i,
	input  logic                                store_byte_i,
	input  logic                                float_read_i,
	input  logic                                store_fp_i,
	input  logic [reg_file_pkg::REG_ADDR_W-1:0] rs_i,
	input  logic [reg_file_pkg::REG_ADDR_W-1:0] rt_i,
	output reg_file_pkg::wr_cmd_t               wr_cmd_o,
	output reg_file_pkg::rd_req_t               rd_req_o
);

	reg_file_pkg::wr_op_e wr_op;
	reg_file_pkg::rd_op_e rd_op;

	// write priority, first match wins
	always_comb begin
		wr_op = reg_file_pkg::WR_NONE;
		if (reg_write_i) begin
			if (wide_write_i && muldiv_i)
				wr_op = reg_file_pkg::WR_HILO;
			else if (wide_write_i && float_write_i)
				wr_op = reg_file_pkg::WR_FP64;
			else if (float_write_i)
				wr_op = reg_file_pkg::WR_FP32; // msw cleared by the bank
			else if (load_byte_i)
				wr_op = reg_file_pkg::WR_INT_BYTE;
			else if (jal_i)
				wr_op = reg_file_pkg::WR_LINK; // address comes from the bank
			else
				wr_op = reg_file_pkg::WR_INT;
		end
	end

	// store-float needs both banks in the same cycle
	always_comb begin
		if (store_fp_i)
			rd_op = reg_file_pkg::RD_STORE_FP;
		else if (float_read_i)
			rd_op = reg_file_pkg::RD_FP;
		else if (store_byte_i)
			rd_op = reg_file_pkg::RD_STORE_BYTE;
		else
			rd_op = reg_file_pkg::RD_INT;
	end

	always_comb begin
		wr_cmd_o.op     = wr_op;
		wr_cmd_o.addr   = wr_addr_i;
		wr_cmd_o.data   = wr_data_i;
		wr_cmd_o.data64 = wr_data64_i;
		rd_req_o.op     = rd_op;
		rd_req_o.rs     = rs_i;
		rd_req_o.rt     = rt_i;
	end

endmodule

// ==== src.f ====
source/reg_file_pkg.sv
source/reg_write_decode.sv
source/int_reg_bank.sv
source/fp_reg_bank.sv
source/read_port_mux.sv
source/mips_reg_file.sv
bench/tb_reg_file.sv
